// ==== common/fdivsqrt_settings.svh ====
`ifndef FDIVSQRT_SETTINGS_SVH
`define FDIVSQRT_SETTINGS_SVH

// binary16 field widths
`define FDS_NE 5
`define FDS_NF 10

// single bias, no other formats
`define FDS_BIAS 15

// recurrence operand width
// hidden bit, fraction, one guard bit and one bit for the odd sqrt radicand
`define FDS_DIVB (`FDS_NF + 3)

// one result bit per cycle
// integer bit, fraction and one bit for the X below D case
`define FDS_DUR (`FDS_NF + 2)

// apb register offsets
`define FDS_ADDR_OPX    32'h0000_0000
`define FDS_ADDR_OPY    32'h0000_0004
`define FDS_ADDR_CTRL   32'h0000_0008
`define FDS_ADDR_STATUS 32'h0000_000C
`define FDS_ADDR_RESULT 32'h0000_0010

`endif

// ==== common/fdivsqrtPkg.sv ====
`default_nettype none

`include "fdivsqrt_settings.svh"

package fdivsqrtPkg;

  // plain field widths
  typedef logic [`FDS_NE-1:0] fdsExpT;
  typedef logic [`FDS_NF-1:0] fdsFracT;
  // significand including the hidden bit
  typedef logic [`FDS_NF:0] fdsSigT;
  // wide enough for a count of NF+1 on an all-zero significand
  typedef logic [$clog2(`FDS_NF+2)-1:0] fdsZeroCntT;
  // signed so negative intermediate exponents halve correctly
  typedef logic signed [`FDS_NE+1:0] fdsQeT;
  // remainder, two bits above the recurrence operand
  typedef logic [`FDS_DIVB+1:0] fdsRemT;

  // one binary16 word as it sits in the registers
  typedef struct packed {
    logic    sign;
    fdsExpT  exp;
    fdsFracT frac;
  } fdsOperandT;

  // everything the recurrence and the packer need, captured at start
  typedef struct packed {
    fdsQeT                qe;
    logic [`FDS_DIVB-1:0] x;
    logic [`FDS_DIVB-1:0] d;
    logic                 sqrt;
    logic                 sign;
    logic                 xZero;
  } fdsPreprocT;

  typedef struct packed {
    logic       done;
    fdsOperandT result;
  } fdsResultT;

  typedef enum logic [1:0] {
    iterIdle,
    iterBusy,
    iterDone
  } fdsIterStateT;

endpackage

`default_nettype wire

// ==== hw/leadingZeroCount.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fdivsqrt_settings.svh"

module leadingZeroCount #(
  parameter int width = `FDS_NF + 1
) (
  input  logic [width-1:0]             sig,
  output fdivsqrtPkg::fdsZeroCntT      cnt
);

  // priority scan from the lsb up
  // the highest set bit is the last one to write cnt
  always_comb begin
    cnt = fdivsqrtPkg::fdsZeroCntT'(width);
    for (int i = 0; i < width; i++) begin
      if (sig[i]) begin
        cnt = fdivsqrtPkg::fdsZeroCntT'(width - 1 - i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== fdivsqrt/fdivsqrtPreproc.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fdivsqrt_settings.svh"

module fdivsqrtPreproc (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    start,
  input  logic                    sqrt,
  input  fdivsqrtPkg::fdsOperandT opX,
  input  fdivsqrtPkg::fdsOperandT opY,
  output fdivsqrtPkg::fdsPreprocT pre
);

  fdivsqrtPkg::fdsExpT     xExp;
  fdivsqrtPkg::fdsExpT     yExp;
  fdivsqrtPkg::fdsSigT     xSig;
  fdivsqrtPkg::fdsSigT     ySig;
  fdivsqrtPkg::fdsSigT     xNorm;
  fdivsqrtPkg::fdsSigT     yNorm;
  fdivsqrtPkg::fdsZeroCntT xZeroCnt;
  fdivsqrtPkg::fdsZeroCntT yZeroCnt;
  fdivsqrtPkg::fdsQeT      qe;
  logic                    xZero;
  logic                    xExpOdd;
  logic [`FDS_DIVB-1:0]    xDiv;
  logic [`FDS_DIVB-1:0]    xSqrt;
  logic [`FDS_DIVB-1:0]    dNorm;

  ////////////////////
  // significands
  ////////////////////

  // subnormals have no hidden bit and behave as exponent 1
  assign xSig = {|opX.exp, opX.frac};
  assign ySig = {|opY.exp, opY.frac};
  assign xExp = (opX.exp == '0) ? fdivsqrtPkg::fdsExpT'(1) : opX.exp;
  assign yExp = (opY.exp == '0) ? fdivsqrtPkg::fdsExpT'(1) : opY.exp;
  assign xZero = (xSig == '0);

  leadingZeroCount #(.width(`FDS_NF + 1)) i_lzcX (.sig(xSig), .cnt(xZeroCnt));
  leadingZeroCount #(.width(`FDS_NF + 1)) i_lzcY (.sig(ySig), .cnt(yZeroCnt));

  // bring the leading one up to the hidden bit position
  assign xNorm = xSig << xZeroCnt;
  assign yNorm = ySig << yZeroCnt;

  ////////////////////
  // operand placement
  ////////////////////

  // bias is odd, so the unbiased exponent is odd when the biased one
  // minus the shift is even
  assign xExpOdd = ~(xExp[0] ^ xZeroCnt[0]);

  // divide keeps the leading one just below the top bit
  assign xDiv  = {1'b0, xNorm, 1'b0};
  assign dNorm = {yNorm, 2'b00};
  // odd exponent uses 2m so the halved exponent is exact
  assign xSqrt = xExpOdd ? {xNorm, 2'b00} : {1'b0, xNorm, 1'b0};

  expCalc i_expCalc (
    .sqrt     (sqrt),
    .xExp     (xExp),
    .yExp     (yExp),
    .xZero    (xZero),
    .xZeroCnt (xZeroCnt),
    .yZeroCnt (yZeroCnt),
    .qe       (qe)
  );

  // everything downstream works from this copy while the host rewrites operands
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pre <= '0;
    end else if (start) begin
      pre.qe    <= qe;
      pre.x     <= sqrt ? xSqrt : xDiv;
      pre.d     <= dNorm;
      pre.sqrt  <= sqrt;
      // root of a non-negative value is positive
      pre.sign  <= sqrt ? 1'b0 : (opX.sign ^ opY.sign);
      pre.xZero <= xZero;
    end
  end

endmodule

module expCalc (
  input  logic                    sqrt,
  input  fdivsqrtPkg::fdsExpT     xExp,
  input  fdivsqrtPkg::fdsExpT     yExp,
  input  logic                    xZero,
  input  fdivsqrtPkg::fdsZeroCntT xZeroCnt,
  input  fdivsqrtPkg::fdsZeroCntT yZeroCnt,
  output fdivsqrtPkg::fdsQeT      qe
);

  fdivsqrtPkg::fdsQeT bias;
  fdivsqrtPkg::fdsQeT xUnbiased;
  fdivsqrtPkg::fdsQeT sqrtExp;
  fdivsqrtPkg::fdsQeT divExp;

  assign bias = fdivsqrtPkg::fdsQeT'(`FDS_BIAS);

  // x exponent corrected for the normalization shift
  assign xUnbiased = fdivsqrtPkg::fdsQeT'(xExp) - fdivsqrtPkg::fdsQeT'(xZeroCnt) - bias;
  // arithmetic shift rounds odd exponents down, matching the 2m radicand
  assign sqrtExp = (xUnbiased >>> 1) + bias;

  assign divExp = xZero ? '0 :
                  fdivsqrtPkg::fdsQeT'(xExp) - fdivsqrtPkg::fdsQeT'(xZeroCnt)
                  - fdivsqrtPkg::fdsQeT'(yExp) + fdivsqrtPkg::fdsQeT'(yZeroCnt) + bias;

  assign qe = sqrt ? sqrtExp : divExp;

endmodule

`default_nettype wire

// ==== fdivsqrt/fdivsqrtIter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fdivsqrt_settings.svh"

module fdivsqrtIter (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    start,
  input  fdivsqrtPkg::fdsPreprocT pre,
  output logic [`FDS_DIVB-1:0]    quot,
  output logic                    remNonZero,
  output logic                    busy,
  output logic                    done
);

  localparam int cntW = $clog2(`FDS_DUR);

  fdivsqrtPkg::fdsIterStateT state;
  fdivsqrtPkg::fdsIterStateT stateNext;
  logic [cntW-1:0]           cnt;
  logic                      first;
  fdivsqrtPkg::fdsRemT       rem;
  fdivsqrtPkg::fdsRemT       remCur;
  fdivsqrtPkg::fdsRemT       remNext;
  fdivsqrtPkg::fdsRemT       divShift;
  fdivsqrtPkg::fdsRemT       sqShift;
  fdivsqrtPkg::fdsRemT       sqTrial;
  logic [`FDS_DIVB+2:0]      divDiff;
  logic [`FDS_DIVB+2:0]      sqDiff;
  logic [`FDS_DIVB-1:0]      rad;
  logic [`FDS_DIVB-1:0]      radCur;
  logic [`FDS_DIVB-1:0]      quotCur;
  logic [1:0]                radPair;
  logic                      qBit;

  ////////////////////
  // control
  ////////////////////

  always_comb begin
    stateNext = state;
    case (state)
      fdivsqrtPkg::iterIdle: begin
        if (start) stateNext = fdivsqrtPkg::iterBusy;
      end
      fdivsqrtPkg::iterBusy: begin
        if (cnt == cntW'(`FDS_DUR - 1)) stateNext = fdivsqrtPkg::iterDone;
      end
      fdivsqrtPkg::iterDone: begin
        stateNext = start ? fdivsqrtPkg::iterBusy : fdivsqrtPkg::iterIdle;
      end
      default: stateNext = fdivsqrtPkg::iterIdle;
    endcase
  end

  // cnt runs only while busy, so it is zero on the first step
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= fdivsqrtPkg::iterIdle;
      cnt   <= '0;
    end else begin
      state <= stateNext;
      if (state == fdivsqrtPkg::iterBusy) cnt <= cnt + 1'b1;
      else cnt <= '0;
    end
  end

  assign busy  = (state == fdivsqrtPkg::iterBusy);
  assign done  = (state == fdivsqrtPkg::iterDone);
  assign first = (cnt == '0);

  ////////////////////
  // recurrence step
  ////////////////////

  // preproc outputs settle at the start edge, so the first step reads them directly
  assign remCur  = first ? (pre.sqrt ? '0 : fdivsqrtPkg::fdsRemT'(pre.x)) : rem;
  assign quotCur = first ? '0 : quot;
  assign radCur  = first ? pre.x : rad;

  // divide, shift then trial subtract the divisor
  assign divShift = {remCur[`FDS_DIVB:0], 1'b0};
  assign divDiff  = {1'b0, divShift} - {3'b000, pre.d};

  // sqrt, bring down two radicand bits and subtract root with 01 appended
  // the partial root never exceeds DIVB-2 bits before the last step
  assign radPair = radCur[`FDS_DIVB-1 -: 2];
  assign sqShift = {remCur[`FDS_DIVB-1:0], radPair};
  assign sqTrial = {2'b00, quotCur[`FDS_DIVB-3:0], 2'b01};
  assign sqDiff  = {1'b0, sqShift} - {1'b0, sqTrial};

  // non-negative difference gives a one and keeps the difference
  assign qBit = pre.sqrt ? ~sqDiff[`FDS_DIVB+2] : ~divDiff[`FDS_DIVB+2];

  always_comb begin
    if (pre.sqrt) begin
      remNext = qBit ? sqDiff[`FDS_DIVB+1:0] : sqShift;
    end else begin
      remNext = qBit ? divDiff[`FDS_DIVB+1:0] : divShift;
    end
  end

  always_ff @(posedge clk) begin
    if (busy) begin
      rem  <= remNext;
      rad  <= radCur << 2;
      quot <= {quotCur[`FDS_DIVB-2:0], qBit};
    end
  end

  assign remNonZero = |rem;

endmodule

`default_nettype wire

// ==== fdivsqrt/fdivsqrtPostproc.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fdivsqrt_settings.svh"

module fdivsqrtPostproc (
  input  fdivsqrtPkg::fdsPreprocT pre,
  input  logic [`FDS_DIVB-1:0]    quot,
  input  logic                    done,
  output fdivsqrtPkg::fdsResultT  result
);

  logic                    leadOne;
  logic [`FDS_DIVB-1:0]    quotNorm;
  fdivsqrtPkg::fdsQeT      qeNorm;
  fdivsqrtPkg::fdsOperandT resWord;

  // integer bit of the result sits at DUR-1
  // only a divide with X below D leaves it clear
  assign leadOne = quot[`FDS_DUR-1];

  assign quotNorm = leadOne ? quot : quot << 1;
  assign qeNorm   = leadOne ? pre.qe : pre.qe - fdivsqrtPkg::fdsQeT'(1);

  ////////////////////
  // packing
  ////////////////////

  always_comb begin
    resWord.sign = pre.sign;
    // low bits only, the exponent range is kept by the host
    resWord.exp  = qeNorm[`FDS_NE-1:0];
    // fraction under the integer bit, guard bit dropped for round toward zero
    resWord.frac = quotNorm[`FDS_DUR-2 -: `FDS_NF];
    // zero in gives zero out, sign already cleared for sqrt
    if (pre.xZero) begin
      resWord.exp  = '0;
      resWord.frac = '0;
    end
  end

  assign result.done   = done;
  assign result.result = resWord;

endmodule

`default_nettype wire

// ==== hw/fdivsqrtApb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fdivsqrt_settings.svh"

module fdivsqrtApb (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [31:0]             paddr,
  input  logic [31:0]             pwdata,
  input  logic                    busy,
  input  fdivsqrtPkg::fdsResultT  result,
  output logic [31:0]             prdata,
  output logic                    pready,
  output logic                    pslverr,
  output logic                    start,
  output logic                    sqrt,
  output fdivsqrtPkg::fdsOperandT opX,
  output fdivsqrtPkg::fdsOperandT opY
);

  logic                    access;
  logic                    wrAccess;
  logic                    rdAccess;
  logic                    addrHit;
  logic                    ctrlWr;
  logic                    startReq;
  logic                    startReject;
  logic                    busyAny;
  logic                    doneReg;
  fdivsqrtPkg::fdsOperandT resultReg;

  assign access   = psel && penable;
  assign wrAccess = access && pwrite;
  assign rdAccess = access && !pwrite;

  // start is still in flight the cycle before iter goes busy
  assign busyAny = busy || start;

  ////////////////////
  // decode
  ////////////////////

  always_comb begin
    case (paddr)
      `FDS_ADDR_OPX,
      `FDS_ADDR_OPY,
      `FDS_ADDR_CTRL,
      `FDS_ADDR_STATUS,
      `FDS_ADDR_RESULT: addrHit = 1'b1;
      default:          addrHit = 1'b0;
    endcase
  end

  assign ctrlWr      = wrAccess && (paddr == `FDS_ADDR_CTRL);
  assign startReq    = ctrlWr && pwdata[0];
  assign startReject = startReq && busyAny;

  // no wait states
  assign pready  = 1'b1;
  assign pslverr = access && (!addrHit || startReject);

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      opX       <= '0;
      opY       <= '0;
      sqrt      <= 1'b0;
      start     <= 1'b0;
      doneReg   <= 1'b0;
      resultReg <= '0;
    end else begin
      // one cycle pulse after the access phase
      start <= startReq && !busyAny;
      if (wrAccess && (paddr == `FDS_ADDR_OPX)) opX <= pwdata[15:0];
      if (wrAccess && (paddr == `FDS_ADDR_OPY)) opY <= pwdata[15:0];
      // a rejected start leaves the whole control word untouched
      if (ctrlWr && !startReject) sqrt <= pwdata[1];
      if (start) begin
        doneReg <= 1'b0;
      end else if (result.done) begin
        doneReg <= 1'b1;
      end
      if (result.done) resultReg <= result.result;
    end
  end

  // read mux, quiet outside read access
  always_comb begin
    prdata = '0;
    if (rdAccess) begin
      case (paddr)
        `FDS_ADDR_OPX:    prdata = {16'h0000, opX};
        `FDS_ADDR_OPY:    prdata = {16'h0000, opY};
        `FDS_ADDR_CTRL:   prdata = {30'd0, sqrt, 1'b0};
        `FDS_ADDR_STATUS: prdata = {30'd0, doneReg, busyAny};
        `FDS_ADDR_RESULT: prdata = {16'h0000, resultReg};
        default:          prdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/fdivsqrtTop.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fdivsqrt_settings.svh"

module fdivsqrtTop (
  input  logic        clk,
  input  logic        rstN,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  logic                    start;
  logic                    sqrt;
  logic                    busy;
  logic                    done;
  logic [`FDS_DIVB-1:0]    quot;
  fdivsqrtPkg::fdsOperandT opX;
  fdivsqrtPkg::fdsOperandT opY;
  fdivsqrtPkg::fdsPreprocT pre;
  fdivsqrtPkg::fdsResultT  result;

  fdivsqrtApb i_fdivsqrtApb (
    .clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata,
    .busy, .result, .prdata, .pready, .pslverr,
    .start, .sqrt, .opX, .opY
  );

  fdivsqrtPreproc i_fdivsqrtPreproc (
    .clk, .rstN, .start, .sqrt, .opX, .opY, .pre
  );

  // sticky remainder flag is not needed while results are truncated
  fdivsqrtIter i_fdivsqrtIter (
    .clk, .rstN, .start, .pre, .quot,
    .remNonZero (),
    .busy, .done
  );

  fdivsqrtPostproc i_fdivsqrtPostproc (
    .pre, .quot, .done, .result
  );

endmodule

`default_nettype wire

// ==== sim/fdivsqrt_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fdivsqrt_settings.svh"

module fdivsqrtAssert (
  input logic clk,
  input logic rstN,
  input logic start,
  input logic busy,
  input logic done,
  input logic pready
);

  // number of failed assertions, looked at by the testbench at the end
  int failCount = 0;

  // start is a single cycle pulse
  startPulse: assert property (@(posedge clk) disable iff (!rstN) start |=> !start)
    else begin
      failCount++;
      $error("start held for more than one cycle");
    end

  // fixed latency of the recurrence
  doneLatency: assert property (@(posedge clk) disable iff (!rstN)
    start |-> ##(`FDS_DUR + 1) done)
    else begin
      failCount++;
      $error("done did not follow start after the iteration count");
    end

  readyHigh: assert property (@(posedge clk) disable iff (!rstN) pready)
    else begin
      failCount++;
      $error("pready dropped");
    end

  busyDone: assert property (@(posedge clk) disable iff (!rstN) !(busy && done))
    else begin
      failCount++;
      $error("busy and done high together");
    end

endmodule

bind fdivsqrtTop fdivsqrtAssert i_fdivsqrtAssert (
  .clk    (clk),
  .rstN   (rstN),
  .start  (start),
  .busy   (busy),
  .done   (done),
  .pready (pready)
);

`default_nettype wire

// ==== sim/fdivsqrtChecker.sv ====
`timescale 1ns/100ps
`default_nettype none

module fdivsqrtChecker (
  input  logic        clk,
  input  logic        rstN,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] paddr,
  input  logic [31:0] prdata,
  input  logic        pready,
  input  logic        pslverr,
  input  logic        checkEn,
  input  logic [31:0] expData,
  input  logic        expErr,
  input  logic        testDone,
  input  int          testId,
  input  logic [63:0] label,
  input  logic        endOfRun,
  input  int          timeouts,
  output int          errorCount
);

  int checkCount;
  int testMark;

  initial begin
    errorCount = 0;
    checkCount = 0;
    testMark   = 0;
  end

  // access phase of an expected transfer, sampled at its closing edge
  always @(posedge clk) begin
    if (rstN && psel && penable && checkEn) begin
      checkCount++;
      if (!pwrite && prdata !== expData) begin
        errorCount++;
        $display("MISMATCH at %0t: read of 0x%0h gave 0x%08h, expected 0x%08h",
                 $time, paddr, prdata, expData);
      end
      if (pslverr !== expErr) begin
        errorCount++;
        $display("MISMATCH at %0t: pslverr at 0x%0h was %b, expected %b",
                 $time, paddr, pslverr, expErr);
      end
      // no wait states on any transfer
      if (pready !== 1'b1) begin
        errorCount++;
        $display("MISMATCH at %0t: pready at 0x%0h was %b, expected 1",
                 $time, paddr, pready);
      end
    end
  end

  // one line per finished test
  always @(posedge clk) begin
    if (testDone) begin
      if (errorCount == testMark) begin
        $display("test %0d %0s: ok", testId, label);
      end else begin
        $display("test %0d %0s: %0d errors", testId, label, errorCount - testMark);
      end
      testMark = errorCount;
    end
  end

  always @(posedge endOfRun) begin
    $display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeouts);
  end

endmodule

`default_nettype wire

// ==== sim/fdivsqrtTb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fdivsqrt_settings.svh"

module fdivsqrtTb;

  typedef struct packed {
    logic        isSqrt;
    logic [15:0] opX;
    logic [15:0] opY;
    logic [15:0] expected;
  } vecT;

  logic        clk;
  logic        rstN;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  // expectations posted to the checker
  logic        checkEn;
  logic [31:0] expData;
  logic        expErr;
  logic        testDone;
  int          testId;
  logic [63:0] label;
  logic        endOfRun;
  int          errorCount;
  int          timeouts;
  integer      seed;
  vecT         vectors[$];

  fdivsqrtTop i_fdivsqrtTop (
    .clk, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr
  );

  fdivsqrtChecker i_fdivsqrtChecker (
    .clk, .rstN, .psel, .penable, .pwrite, .paddr, .prdata, .pready, .pslverr,
    .checkEn, .expData, .expErr, .testDone, .testId, .label, .endOfRun,
    .timeouts, .errorCount
  );

  // 20 ns period
  always #10 clk = ~clk;

  ////////////////////
  // apb driver
  ////////////////////

  // setup on one falling edge, access on the next, idle after the sample
  task automatic apbAccess(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic doCheck, input logic [31:0] expD, input logic expE,
                           output logic [31:0] data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    checkEn = doCheck;
    expData = expD;
    expErr  = expE;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    data = prdata;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    checkEn = 1'b0;
  endtask

  task automatic apbWrite(input logic [31:0] addr, input logic [31:0] wdata, input logic expE);
    logic [31:0] unused;
    apbAccess(1'b1, addr, wdata, 1'b1, 32'h0, expE, unused);
  endtask

  task automatic apbCheckRead(input logic [31:0] addr, input logic [31:0] expD,
                              input logic expE);
    logic [31:0] unused;
    apbAccess(1'b0, addr, 32'h0, 1'b1, expD, expE, unused);
  endtask

  // done bit polled with its own limit
  task automatic waitDone();
    logic [31:0] status;
    int          polls;
    status = '0;
    polls  = 0;
    while (!status[1] && polls < 100) begin
      apbAccess(1'b0, `FDS_ADDR_STATUS, 32'h0, 1'b0, 32'h0, 1'b0, status);
      polls++;
    end
    if (!status[1]) begin
      timeouts++;
      $display("timeout at %0t: the done bit was still clear after 100 status polls", $time);
    end
  endtask

  task automatic finishTest(input logic [63:0] name);
    @(negedge clk);
    label    = name;
    testDone = 1'b1;
    @(negedge clk);
    testDone = 1'b0;
    testId++;
  endtask

  task automatic addRow(input logic isSqrt, input logic [15:0] x, input logic [15:0] y,
                        input logic [15:0] expected);
    vectors.push_back('{isSqrt, x, y, expected});
  endtask

  // value truncated to 10 fraction bits, normal operands only
  function automatic logic [15:0] expectedResult(input logic isSqrt, input logic [15:0] x,
                                                 input logic [15:0] y);
    real mx;
    real my;
    real r;
    int  e;
    int  frac;
    logic sign;
    mx = 1.0 + x[9:0] / 1024.0;
    my = 1.0 + y[9:0] / 1024.0;
    if (isSqrt) begin
      sign = 1'b0;
      e    = int'(x[14:10]) - 15;
      r    = mx;
      if (e % 2 != 0) begin
        r = r * 2.0;
        e = e - 1;
      end
      e = e / 2 + 15;
      r = $sqrt(r);
    end else begin
      sign = x[15] ^ y[15];
      e    = int'(x[14:10]) - int'(y[14:10]) + 15;
      r    = mx / my;
      if (r < 1.0) begin
        r = r * 2.0;
        e = e - 1;
      end
    end
    frac = int'($floor((r - 1.0) * 1024.0));
    return {sign, e[4:0], frac[9:0]};
  endfunction

  initial begin
    logic [15:0] x;
    logic [15:0] y;
    logic        s;
    clk      = 1'b0;
    rstN     = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    checkEn  = 1'b0;
    expData  = '0;
    expErr   = 1'b0;
    testDone = 1'b0;
    testId   = 0;
    label    = "";
    endOfRun = 1'b0;
    timeouts = 0;
    seed     = 32'h79c6_0585;

    // divides, exact and inexact, X below D included
    addRow(1'b0, 16'h3C00, 16'h3C00, 16'h3C00);
    addRow(1'b0, 16'h4600, 16'h4000, 16'h4200);
    addRow(1'b0, 16'h3C00, 16'h4200, 16'h3555);
    addRow(1'b0, 16'h4000, 16'h4200, 16'h3955);
    addRow(1'b0, 16'hBC00, 16'h4200, 16'hB555);
    addRow(1'b0, 16'h3C00, 16'h4700, 16'h3092);
    addRow(1'b0, 16'h4500, 16'h4200, 16'h3EAA);
    // roots, even and odd exponents
    addRow(1'b1, 16'h4400, 16'h0000, 16'h4000);
    addRow(1'b1, 16'h4000, 16'h0000, 16'h3DA8);
    addRow(1'b1, 16'h4880, 16'h0000, 16'h4200);
    addRow(1'b1, 16'h3400, 16'h0000, 16'h3800);
    // subnormal operands
    addRow(1'b0, 16'h0001, 16'h0001, 16'h3C00);
    addRow(1'b0, 16'h0200, 16'h1400, 16'h2800);
    addRow(1'b0, 16'h3C00, 16'h0200, 16'h7800);
    addRow(1'b1, 16'h0100, 16'h0000, 16'h1C00);
    addRow(1'b1, 16'h0200, 16'h0000, 16'h1DA8);
    // zeros
    addRow(1'b0, 16'h0000, 16'h4000, 16'h0000);
    addRow(1'b0, 16'h8000, 16'h4000, 16'h8000);
    addRow(1'b0, 16'h0000, 16'hC000, 16'h8000);
    addRow(1'b1, 16'h0000, 16'h0000, 16'h0000);
    // random normals, exponents kept clear of overflow and underflow
    for (int i = 0; i < 20; i++) begin
      s = i[0];
      if (s) begin
        x = {1'b0, 5'(1 + $unsigned($random(seed)) % 30), 10'($random(seed))};
        y = 16'h0000;
      end else begin
        x = {1'($random(seed)), 5'(10 + $unsigned($random(seed)) % 11), 10'($random(seed))};
        y = {1'($random(seed)), 5'(10 + $unsigned($random(seed)) % 11), 10'($random(seed))};
      end
      addRow(s, x, y, expectedResult(s, x, y));
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    ////////////////////
    // registers
    ////////////////////
    apbCheckRead(`FDS_ADDR_OPX, 32'h0, 1'b0);
    apbCheckRead(`FDS_ADDR_OPY, 32'h0, 1'b0);
    apbCheckRead(`FDS_ADDR_CTRL, 32'h0, 1'b0);
    apbCheckRead(`FDS_ADDR_STATUS, 32'h0, 1'b0);
    apbCheckRead(`FDS_ADDR_RESULT, 32'h0, 1'b0);
    apbWrite(`FDS_ADDR_OPX, 32'h1234, 1'b0);
    apbWrite(`FDS_ADDR_OPY, 32'hABCD, 1'b0);
    apbCheckRead(`FDS_ADDR_OPX, 32'h1234, 1'b0);
    apbCheckRead(`FDS_ADDR_OPY, 32'hABCD, 1'b0);
    apbCheckRead(32'h20, 32'h0, 1'b1);
    finishTest("regs");

    ////////////////////
    // start while busy
    ////////////////////
    apbWrite(`FDS_ADDR_OPX, 32'h3C00, 1'b0);
    apbWrite(`FDS_ADDR_OPY, 32'h4200, 1'b0);
    apbWrite(`FDS_ADDR_CTRL, 32'h1, 1'b0);
    // a sqrt start now must bounce and leave the divide running
    apbWrite(`FDS_ADDR_CTRL, 32'h3, 1'b1);
    apbCheckRead(`FDS_ADDR_STATUS, 32'h1, 1'b0);
    waitDone();
    apbCheckRead(`FDS_ADDR_RESULT, 32'h3555, 1'b0);
    finishTest("busy");

    foreach (vectors[i]) begin
      apbWrite(`FDS_ADDR_OPX, {16'h0, vectors[i].opX}, 1'b0);
      apbWrite(`FDS_ADDR_OPY, {16'h0, vectors[i].opY}, 1'b0);
      apbWrite(`FDS_ADDR_CTRL, {30'd0, vectors[i].isSqrt, 1'b1}, 1'b0);
      // done of the previous result clears with the new start
      apbCheckRead(`FDS_ADDR_STATUS, 32'h1, 1'b0);
      waitDone();
      apbCheckRead(`FDS_ADDR_RESULT, {16'h0, vectors[i].expected}, 1'b0);
      finishTest(vectors[i].isSqrt ? "sqrt" : "div");
    end

    endOfRun = 1'b1;
    @(posedge clk);
    @(negedge clk);
    if (errorCount == 0 && timeouts == 0 &&
        i_fdivsqrtTop.i_fdivsqrtAssert.failCount == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/fdivsqrtPkg.sv
hw/leadingZeroCount.sv
fdivsqrt/fdivsqrtPreproc.sv
fdivsqrt/fdivsqrtIter.sv
fdivsqrt/fdivsqrtPostproc.sv
hw/fdivsqrtApb.sv
hw/fdivsqrtTop.sv
sim/fdivsqrt_assert.sv
sim/fdivsqrtChecker.sv
sim/fdivsqrtTb.sv

// ==== Bender.yml ====
package:
  name: fdivsqrt

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/fdivsqrtPkg.sv
      - hw/leadingZeroCount.sv
      - fdivsqrt/fdivsqrtPreproc.sv
      - fdivsqrt/fdivsqrtIter.sv
      - fdivsqrt/fdivsqrtPostproc.sv
      - hw/fdivsqrtApb.sv
      - hw/fdivsqrtTop.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - sim/fdivsqrt_assert.sv
      - sim/fdivsqrtChecker.sv
      - sim/fdivsqrtTb.sv
